// File: source/mtx_consts.svh
//######################################################################
// fixed widths for the mesh tx link; the module ports follow these
// the packet width must be a whole multiple of the beat width
//######################################################################
`ifndef MTX_CONSTS_SVH
`define MTX_CONSTS_SVH

// pin bus width
`define MTX_NMIO 8

// one beat carries two pin words
`define MTX_BEAT_W (2 * `MTX_NMIO)

// core packet width
`define MTX_PW 64

// beats per core packet
`define MTX_NBEATS (`MTX_PW / `MTX_BEAT_W)

`endif

// File: source/mtx_pkg.sv
//######################################################################
// shared types of the mesh tx link, widths come from the consts header
//######################################################################
`default_nettype none

`include "mtx_consts.svh"

package mtx_pkg;

   // one word on the pins
   typedef logic [`MTX_NMIO-1:0] mtx_pin_t;

   // one beat, upper and lower pin word
   typedef logic [`MTX_BEAT_W-1:0] mtx_beat_t;

   // one core packet
   typedef logic [`MTX_PW-1:0] mtx_packet_t;

   // serializer fsm
   typedef enum logic [0:0] {
      IDLE = 1'b0,
      SEND = 1'b1
   } mtx_ser_state_t;

endpackage

`default_nettype wire

// File: source/mtx_serializer.sv
//######################################################################
// splits a core packet into beats, beat 0 is the lowest half-word pair
// core may only strobe core_access while core_wait is low
//######################################################################
`timescale 1ns/1ns
`default_nettype none

`include "mtx_consts.svh"

module mtx_serializer (
   input  wire                  io_clk,
   input  wire                  rst_sync_n,
   // core side
   input  wire                  core_access,
   input  mtx_pkg::mtx_packet_t core_packet,
   output logic                 core_wait,
   // io block side
   output logic                 io_access,
   output mtx_pkg::mtx_beat_t   io_packet,
   input  wire                  io_wait
);

   //####################################################################
   // declarations
   //####################################################################

   // beat counter width
   localparam int CNT_W = $clog2(`MTX_NBEATS);

   // index of the final beat
   localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`MTX_NBEATS - 1);

   mtx_pkg::mtx_ser_state_t state_q;

   // packet still to go, current beat in the low bits
   mtx_pkg::mtx_packet_t shift_q;

   // beats already taken by the io block
   logic [CNT_W-1:0] beat_cnt_q;

   // beat accepted at this edge
   logic beat_done;

   // final beat of the packet accepted at this edge
   logic last_done;

   //####################################################################
   // handshake
   //####################################################################

   // io block pulls a beat when it does not push back
   assign beat_done = io_access & ~io_wait;
   assign last_done = beat_done & (beat_cnt_q == LAST_BEAT);

   // busy for the whole packet
   assign core_wait = (state_q == mtx_pkg::SEND);

   // beat valid while sending
   assign io_access = (state_q == mtx_pkg::SEND);

   // low slice of the shift register is the current beat
   assign io_packet = shift_q[`MTX_BEAT_W-1:0];

   //####################################################################
   // fsm
   //####################################################################

   always_ff @(posedge io_clk or negedge rst_sync_n) begin
      if (!rst_sync_n) begin
         state_q <= mtx_pkg::IDLE;
      end else begin
         case (state_q)
            mtx_pkg::IDLE: begin
               // new packet from core
               if (core_access) begin
                  state_q <= mtx_pkg::SEND;
               end
            end
            mtx_pkg::SEND: begin
               // done after the final beat goes out
               if (last_done) begin
                  state_q <= mtx_pkg::IDLE;
               end
            end
            default: begin
               state_q <= mtx_pkg::IDLE;
            end
         endcase
      end
   end

   // beat counter, restarts with each packet
   always_ff @(posedge io_clk or negedge rst_sync_n) begin
      if (!rst_sync_n) begin
         beat_cnt_q <= '0;
      end else if (state_q == mtx_pkg::IDLE) begin
         beat_cnt_q <= '0;
      end else if (beat_done) begin
         beat_cnt_q <= beat_cnt_q + 1'b1;
      end
   end

   //####################################################################
   // packet shift register
   //####################################################################

   // load on accept, then drop one beat per accepted beat
   always_ff @(posedge io_clk) begin
      if ((state_q == mtx_pkg::IDLE) && core_access) begin
         shift_q <= core_packet;
      end else if (beat_done) begin
         shift_q <= {{`MTX_BEAT_W{1'b0}}, shift_q[`MTX_PW-1:`MTX_BEAT_W]};
      end
   end

   //####################################################################
   // checks
   //####################################################################

   // core must respect the busy level
   a_core_no_access_when_busy : assert property (
      @(posedge io_clk) disable iff (!rst_sync_n)
      core_wait |-> !core_access
   );

   // a stalled beat holds until the io block takes it
   a_beat_stable_on_wait : assert property (
      @(posedge io_clk) disable iff (!rst_sync_n)
      (io_access && io_wait) |=> (io_access && $stable(io_packet))
   );

endmodule

`default_nettype wire

// File: source/mtx_io.sv
//######################################################################
// pin side of the tx link; sdr sends upper then lower half per beat
// tx_wait is used as is, the pins must supply it in the io_clk domain
//######################################################################
`timescale 1ns/1ns
`default_nettype none

`include "mtx_consts.svh"

module mtx_io (
   input  wire                io_clk,
   input  wire                io_nreset,
   // mode levels
   input  wire                ddr_mode,
   input  wire                lsbfirst,
   // synced reset for the rest of the link
   output logic               rst_sync_n,
   // pins
   output logic               tx_access,
   output mtx_pkg::mtx_pin_t  tx_packet,
   input  wire                tx_wait,
   // serializer side
   input  wire                io_access,
   input  mtx_pkg::mtx_beat_t io_packet,
   output logic               io_wait
);

   //####################################################################
   // declarations
   //####################################################################

   // reset sync stages
   logic [1:0] rst_sync_q;

   // upper half already taken, held set in ddr where a beat goes out whole
   logic sdr_half_q;

   // high on the first sdr cycle of a beat, holds the serializer
   logic byte0_sel;

   // pin word for sdr
   mtx_pkg::mtx_pin_t tx_packet_sdr;

   // beat with halves in pin order for ddr
   mtx_pkg::mtx_beat_t ddr_data;

   // ddr output register
   mtx_pkg::mtx_pin_t ddr_rise_q;
   mtx_pkg::mtx_pin_t ddr_hold_q;
   mtx_pkg::mtx_pin_t ddr_fall_q;
   mtx_pkg::mtx_pin_t tx_packet_ddr;

   // io block takes new data at this edge
   logic take;

   //####################################################################
   // reset sync
   //####################################################################

   // async assert, release after two io_clk edges
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         rst_sync_q <= 2'b00;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b1};
      end
   end

   assign rst_sync_n = rst_sync_q[1];

   //####################################################################
   // access
   //####################################################################

   always_ff @(posedge io_clk or negedge rst_sync_n) begin
      if (!rst_sync_n) begin
         tx_access <= 1'b0;
      end else begin
         tx_access <= io_access;
      end
   end

   // pins stall every data register
   assign take = io_access & ~tx_wait;

   //####################################################################
   // sdr half select
   //####################################################################

   // toggles per sdr beat cycle, idle clears it, ddr keeps it set
   always_ff @(posedge io_clk or negedge rst_sync_n) begin
      if (!rst_sync_n) begin
         sdr_half_q <= 1'b0;
      end else if (ddr_mode) begin
         sdr_half_q <= 1'b1;
      end else if (!io_access) begin
         sdr_half_q <= 1'b0;
      end else if (!tx_wait) begin
         sdr_half_q <= ~sdr_half_q;
      end
   end

   assign byte0_sel = io_access & ~sdr_half_q;

   // first cycle upper half, second cycle lower half
   always_ff @(posedge io_clk) begin
      if (take) begin
         tx_packet_sdr <= byte0_sel ? io_packet[`MTX_BEAT_W-1:`MTX_NMIO] :
                                      io_packet[`MTX_NMIO-1:0];
      end
   end

   // serializer moves on only after the lower half
   assign io_wait = tx_wait | byte0_sel;

   //####################################################################
   // ddr output register
   //####################################################################

   // msb first swaps the halves, low slice goes out on clock high
   assign ddr_data = (ddr_mode && !lsbfirst) ?
                     {io_packet[`MTX_NMIO-1:0], io_packet[`MTX_BEAT_W-1:`MTX_NMIO]} :
                     io_packet;

   // both halves sampled on the rising edge
   always_ff @(posedge io_clk) begin
      if (take) begin
         ddr_rise_q <= ddr_data[`MTX_NMIO-1:0];
         ddr_hold_q <= ddr_data[`MTX_BEAT_W-1:`MTX_NMIO];
      end
   end

   // second half moves over on the falling edge
   always_ff @(negedge io_clk) begin
      ddr_fall_q <= ddr_hold_q;
   end

   assign tx_packet_ddr = io_clk ? ddr_rise_q : ddr_fall_q;

   //####################################################################
   // pin mux
   //####################################################################

   assign tx_packet = ddr_mode ? tx_packet_ddr : tx_packet_sdr;

   // ddr has no half split, io_wait must follow tx_wait only
   a_no_byte0_in_ddr : assert property (
      @(posedge io_clk) disable iff (!rst_sync_n)
      ddr_mode |-> !byte0_sel
   );

endmodule

`default_nettype wire

// File: source/mtx_link.sv
//######################################################################
// mesh tx link top; ddr_mode and lsbfirst are static levels
// first tx_access follows core_access by two cycles
//######################################################################
`timescale 1ns/1ns
`default_nettype none

module mtx_link (
   input  wire                  io_clk,
   input  wire                  io_nreset,
   // mode levels
   input  wire                  ddr_mode,
   input  wire                  lsbfirst,
   // core side
   input  wire                  core_access,
   input  mtx_pkg::mtx_packet_t core_packet,
   output logic                 core_wait,
   // pins
   output logic                 tx_access,
   output mtx_pkg::mtx_pin_t    tx_packet,
   input  wire                  tx_wait
);

   //####################################################################
   // internal nets
   //####################################################################

   // reset released in io_clk domain
   logic rst_sync_n;

   // beat path between serializer and io block
   logic               io_access;
   mtx_pkg::mtx_beat_t io_packet;
   logic               io_wait;

   //####################################################################
   // serializer
   //####################################################################

   mtx_serializer u_serializer (
      .io_clk      (io_clk),
      .rst_sync_n  (rst_sync_n),
      .core_access (core_access),
      .core_packet (core_packet),
      .core_wait   (core_wait),
      .io_access   (io_access),
      .io_packet   (io_packet),
      .io_wait     (io_wait)
   );

   //####################################################################
   // io block, also owns the reset sync
   //####################################################################

   mtx_io u_io (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .ddr_mode   (ddr_mode),
      .lsbfirst   (lsbfirst),
      .rst_sync_n (rst_sync_n),
      .tx_access  (tx_access),
      .tx_packet  (tx_packet),
      .tx_wait    (tx_wait),
      .io_access  (io_access),
      .io_packet  (io_packet),
      .io_wait    (io_wait)
   );

endmodule

`default_nettype wire

// File: test/mtx_link_tb.sv
//######################################################################
// drives mtx_link in sdr and ddr mode; ddr words are sampled mid-phase
// modes only change while the link is idle
//######################################################################
`timescale 1ns/1ns
`default_nettype none

`include "mtx_consts.svh"

module mtx_link_tb;

   // 40 ns clock
   localparam int CLK_HALF = 20;
   localparam int WORDS = 2 * `MTX_NBEATS;
   // packets sent over all tests
   localparam int N_PKTS = 20;
   localparam int LIMIT_CYC = N_PKTS * 2 * `MTX_NBEATS * 4 + 200;

   logic io_clk;
   logic io_nreset;
   logic ddr_mode;
   logic lsbfirst;
   logic core_access;
   mtx_pkg::mtx_packet_t core_packet;
   logic core_wait;
   logic tx_access;
   mtx_pkg::mtx_pin_t tx_packet;
   logic tx_wait;

   // expected pin words and their slot within the packet
   mtx_pkg::mtx_pin_t sb_q[$];
   int idx_q[$];

   integer seed = 32'h751b;
   integer wait_seed = 32'h751b;
   string test_name = "none";
   int err_cnt = 0;
   int err_at_start;
   int n_tests = 0;
   int n_ok = 0;
   logic wait_en;
   logic len_chk_en;
   logic first_sent;

   // word handed to the checks
   logic chk_tick;
   logic chk_extra;
   logic chk_cw;
   int chk_idx;
   mtx_pkg::mtx_pin_t chk_exp;
   mtx_pkg::mtx_pin_t chk_act;

   // acceptance pipe and tx_access run length
   logic [1:0] acc_d;
   logic tx_access_q;
   int run_len;
   logic fresh;

   mtx_link DUT (
      .io_clk      (io_clk),
      .io_nreset   (io_nreset),
      .ddr_mode    (ddr_mode),
      .lsbfirst    (lsbfirst),
      .core_access (core_access),
      .core_packet (core_packet),
      .core_wait   (core_wait),
      .tx_access   (tx_access),
      .tx_packet   (tx_packet),
      .tx_wait     (tx_wait)
   );

   initial begin
      io_clk = 1'b0;
      forever #CLK_HALF io_clk = ~io_clk;
   end

   initial begin
      #(LIMIT_CYC * 2 * CLK_HALF);
      $display("run timed out, link stopped delivering words in %s", test_name);
      $display("tests failed");
      $finish;
   end

   //####################################################################
   // stimulus helpers
   //####################################################################

   // eight distinct words, odd step keeps them apart mod 256
   function automatic mtx_pkg::mtx_packet_t rand_packet();
      mtx_pkg::mtx_packet_t pkt;
      mtx_pkg::mtx_pin_t start;
      mtx_pkg::mtx_pin_t step;
      int i;
      start = mtx_pkg::mtx_pin_t'($random(seed));
      step = mtx_pkg::mtx_pin_t'($random(seed)) | 1;
      for (i = 0; i < WORDS; i++) begin
         pkt[i*`MTX_NMIO +: `MTX_NMIO] = start + mtx_pkg::mtx_pin_t'(i) * step;
      end
      return pkt;
   endfunction

   // pin order: upper first unless ddr with lsbfirst
   task automatic push_expected(input mtx_pkg::mtx_packet_t pkt);
      mtx_pkg::mtx_beat_t beat;
      int k;
      for (k = 0; k < `MTX_NBEATS; k++) begin
         beat = pkt[k*`MTX_BEAT_W +: `MTX_BEAT_W];
         if (ddr_mode && lsbfirst) begin
            sb_q.push_back(beat[`MTX_NMIO-1:0]);
            sb_q.push_back(beat[`MTX_BEAT_W-1:`MTX_NMIO]);
         end else begin
            sb_q.push_back(beat[`MTX_BEAT_W-1:`MTX_NMIO]);
            sb_q.push_back(beat[`MTX_NMIO-1:0]);
         end
         idx_q.push_back(2 * k);
         idx_q.push_back(2 * k + 1);
      end
   endtask

   // strobe as soon as the link is free
   task automatic send_packet(input mtx_pkg::mtx_packet_t pkt);
      while (core_wait) @(negedge io_clk);
      push_expected(pkt);
      core_packet = pkt;
      core_access = 1'b1;
      first_sent = 1'b1;
      @(negedge io_clk);
      core_access = 1'b0;
   endtask

   task automatic drain();
      while (core_wait || sb_q.size() != 0) @(negedge io_clk);
      repeat (3) @(negedge io_clk);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_at_start = err_cnt;
   endtask

   task automatic end_test();
      a_all_words_seen : assert (sb_q.size() == 0) else begin
         $display("%s: %0d words never reached the pins", test_name, sb_q.size());
         err_cnt++;
      end
      n_tests++;
      if (err_cnt == err_at_start) begin
         n_ok++;
      end
      $display("test %-14s %s", test_name, (err_cnt == err_at_start) ? "ok" : "with errors");
   endtask

   // random pin back-pressure
   always @(negedge io_clk) begin
      if (wait_en) begin
         tx_wait = (($random(wait_seed) & 3) == 0);
      end else begin
         tx_wait = 1'b0;
      end
   end

   //####################################################################
   // monitor and checks
   //####################################################################

   task automatic check_word();
      chk_act = tx_packet;
      chk_cw = core_wait;
      chk_extra = (sb_q.size() == 0);
      if (!chk_extra) begin
         chk_exp = sb_q.pop_front();
         chk_idx = idx_q.pop_front();
      end
      #2 chk_tick = 1'b1;
      #2 chk_tick = 1'b0;
   endtask

   // new word only after an edge without tx_wait
   always @(posedge io_clk) begin
      fresh = !tx_wait;
      #(CLK_HALF / 2);
      if (tx_access && fresh) begin
         check_word();
      end
      if (ddr_mode) begin
         #(CLK_HALF - 4);
         if (tx_access && fresh) begin
            check_word();
         end
      end
   end

   always @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         acc_d <= 2'b00;
         tx_access_q <= 1'b0;
         run_len <= 0;
      end else begin
         acc_d <= {acc_d[0], core_access & ~core_wait};
         tx_access_q <= tx_access;
         run_len <= tx_access ? run_len + 1 : 0;
      end
   end

   a_word_match : assert property (@(posedge chk_tick) !chk_extra |-> (chk_act == chk_exp))
      else begin
         $display("** Error: %s word %0d expected %h actual %h",
                  test_name, chk_idx, chk_exp, chk_act);
         err_cnt++;
      end

   a_no_extra_word : assert property (@(posedge chk_tick) !chk_extra)
      else begin
         $display("%s: word %h showed up on the pins but was never sent", test_name, chk_act);
         err_cnt++;
      end

   // busy through the first beats, free once the last word is out
   a_busy_early : assert property (@(posedge chk_tick)
      (!chk_extra && chk_idx < WORDS - 2) |-> chk_cw)
      else begin
         $display("** Error: %s core_wait at word %0d expected 1 actual 0", test_name, chk_idx);
         err_cnt++;
      end

   a_free_at_end : assert property (@(posedge chk_tick)
      (!chk_extra && chk_idx == WORDS - 1) |-> !chk_cw)
      else begin
         $display("** Error: %s core_wait at last word expected 0 actual 1", test_name);
         err_cnt++;
      end

   a_idle_after_reset : assert property (@(posedge io_clk) disable iff (!io_nreset)
      !first_sent |-> (!tx_access && !core_wait))
      else begin
         $display("%s: link left idle before any packet was sent", test_name);
         err_cnt++;
      end

   a_tx_latency : assert property (@(posedge io_clk) disable iff (!io_nreset)
      acc_d[1] |-> (tx_access && !tx_access_q))
      else begin
         $display("** Error: %s tx_access 2 cycles after accept expected 1 actual %b",
                  test_name, $sampled(tx_access));
         err_cnt++;
      end

   a_tx_length : assert property (@(posedge io_clk) disable iff (!io_nreset)
      (len_chk_en && tx_access_q && !tx_access) |->
      (run_len == (ddr_mode ? `MTX_NBEATS : WORDS)))
      else begin
         $display("** Error: %s tx_access cycles expected %0d actual %0d", test_name,
                  ddr_mode ? `MTX_NBEATS : WORDS, $sampled(run_len));
         err_cnt++;
      end

   a_core_rule : assert property (@(posedge io_clk) disable iff (!io_nreset)
      core_access |-> !core_wait)
      else begin
         $display("%s: core_access raised while the link was busy", test_name);
         err_cnt++;
      end

   //####################################################################
   // tests
   //####################################################################

   initial begin
      io_nreset = 1'b0;
      ddr_mode = 1'b0;
      lsbfirst = 1'b1;
      core_access = 1'b0;
      core_packet = '0;
      tx_wait = 1'b0;
      wait_en = 1'b0;
      len_chk_en = 1'b0;
      first_sent = 1'b0;
      chk_tick = 1'b0;
      chk_extra = 1'b0;
      chk_cw = 1'b0;
      chk_idx = 0;
      chk_exp = '0;
      chk_act = '0;
      repeat (3) @(posedge io_clk);
      @(negedge io_clk);
      io_nreset = 1'b1;

      start_test("reset_idle");
      repeat (8) @(negedge io_clk);
      end_test();

      start_test("sdr_order");
      len_chk_en = 1'b1;
      send_packet(64'h8877_6655_4433_2211);
      drain();
      send_packet(rand_packet());
      drain();
      end_test();

      start_test("ddr_lsb_first");
      ddr_mode = 1'b1;
      send_packet(64'h8877_6655_4433_2211);
      drain();
      send_packet(rand_packet());
      drain();
      end_test();

      start_test("ddr_msb_first");
      lsbfirst = 1'b0;
      send_packet(rand_packet());
      drain();
      send_packet(rand_packet());
      drain();
      end_test();

      // run lengths stretch under back-pressure
      start_test("wait_pulses");
      len_chk_en = 1'b0;
      ddr_mode = 1'b0;
      wait_en = 1'b1;
      repeat (3) send_packet(rand_packet());
      drain();
      wait_en = 1'b0;
      @(negedge io_clk);
      ddr_mode = 1'b1;
      wait_en = 1'b1;
      repeat (3) send_packet(rand_packet());
      drain();
      wait_en = 1'b0;
      repeat (2) @(negedge io_clk);
      end_test();

      start_test("back_to_back");
      len_chk_en = 1'b1;
      ddr_mode = 1'b0;
      repeat (4) send_packet(rand_packet());
      drain();
      ddr_mode = 1'b1;
      lsbfirst = 1'b1;
      repeat (4) send_packet(rand_packet());
      drain();
      end_test();

      $display("%0d of %0d tests ok, %0d errors", n_ok, n_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: mtx_link.f
+incdir+source
source/mtx_pkg.sv
source/mtx_serializer.sv
source/mtx_io.sv
source/mtx_link.sv
test/mtx_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the mesh tx link testbench with verilator and runs it
# the run counts as passed only if the pass line shows up in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f mtx_link.f \
   --top-module mtx_link_tb || { echo "verilator build failed"; exit 1; }
sim_out="$(./obj_dir/Vmtx_link_tb)"
echo "$sim_out"
echo "$sim_out" | grep -qx "all tests passed" &&
   echo "simulation PASS" && exit 0 ||
   { echo "simulation FAIL"; exit 1; }
